//--- hw/neopixel_cfg_pkg.sv
package neopixel_cfg_pkg;

    //////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////

    // Every timing value and the phase timer share this width
    localparam int CounterWidth = 16;
    // Register address width
    localparam int CfgAddrWidth = 3;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    localparam logic [CfgAddrWidth-1:0] AddrT0h      = 3'd0;
    localparam logic [CfgAddrWidth-1:0] AddrT0l      = 3'd1;
    localparam logic [CfgAddrWidth-1:0] AddrT1h      = 3'd2;
    localparam logic [CfgAddrWidth-1:0] AddrT1l      = 3'd3;
    localparam logic [CfgAddrWidth-1:0] AddrTLatch   = 3'd4;
    localparam logic [CfgAddrWidth-1:0] AddrNumPixel = 3'd5;

    // Reset timing in cycles of a 100 MHz clock
    localparam logic [CounterWidth-1:0] DefT0h    = 16'd40;
    localparam logic [CounterWidth-1:0] DefT0l    = 16'd85;
    localparam logic [CounterWidth-1:0] DefT1h    = 16'd80;
    localparam logic [CounterWidth-1:0] DefT1l    = 16'd45;
    // Reset/latch gap, 50 us
    localparam logic [CounterWidth-1:0] DefTLatch = 16'd5000;

endpackage

//--- hw/neopixel_fifo.sv
`timescale 1ns/1ps

module neopixel_fifo (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Write side, dropped when full
    input  logic                                      push_i,
    input  logic [neopixel_pixel_pkg::ColorWidth-1:0] push_data_i,
    // Read side, head shown without read latency
    input  logic                                      pop_i,
    output logic [neopixel_pixel_pkg::ColorWidth-1:0] head_o,
    output logic                                      empty_o,
    output logic                                      full_o
);

    import neopixel_pixel_pkg::*;

    // Colour storage
    logic [ColorWidth-1:0] mem_q [FifoDepth];

    // Pointers wrap on their own, depth is a power of two
    logic [FifoAddrWidth-1:0] wr_ptr_q;
    logic [FifoAddrWidth-1:0] rd_ptr_q;
    // One extra bit so a full buffer is distinct from an empty one
    logic [FifoAddrWidth:0]   count_q;

    logic do_push;
    logic do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == FifoDepth);
    assign head_o  = mem_q[rd_ptr_q];

    // Qualified strobes
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            // Push and pop together leave occupancy unchanged
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hw/neopixel_fsm.sv
`timescale 1ns/1ps

module neopixel_fsm (
    input  logic                                           clk_i,
    input  logic                                           rst_i,
    // FIFO status
    input  logic                                           fifo_empty_i,
    // Configuration
    input  logic [neopixel_pixel_pkg::PixelCountWidth-1:0] num_neopixel_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0]      t0h_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0]      t0l_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0]      t1h_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0]      t1l_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0]      t_latch_i,
    // Shifter and timer status
    input  logic                                           cur_bit_i,
    input  logic                                           last_bit_i,
    input  logic                                           timer_last_i,
    // Datapath control
    output logic                                           fifo_pop_o,
    output logic                                           shift_load_o,
    output logic                                           load_zero_o,
    output logic                                           shift_next_o,
    output logic                                           timer_clear_o,
    output logic                                           timer_en_o,
    output logic [neopixel_cfg_pkg::CounterWidth-1:0]      timer_len_o,
    // Serial line and status
    output logic                                           data_o,
    output logic                                           busy_o
);

    import neopixel_pixel_pkg::*;

    typedef enum logic [1:0] {
        // Waiting for colour data
        IDLE,
        // High part of a bit
        BIT_HIGH,
        // Low part of a bit
        BIT_LOW,
        // Line held low so the strip latches
        LATCH
    } state_t;

    state_t state_q, state_d;

    // Pixel position inside the frame
    logic [PixelCountWidth-1:0] pixel_q, pixel_d;

    // Line is high only during the high phase
    assign data_o = (state_q == BIT_HIGH);
    assign busy_o = (state_q != IDLE);

    //////////////////////////////////////////////////
    // Phase length select
    //////////////////////////////////////////////////

    always_comb begin
        case (state_q)
            BIT_HIGH: timer_len_o = cur_bit_i ? t1h_i : t0h_i;
            BIT_LOW:  timer_len_o = cur_bit_i ? t1l_i : t0l_i;
            default:  timer_len_o = t_latch_i;
        endcase
    end

    //////////////////////////////////////////////////
    // Next state and control strobes
    //////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        pixel_d       = pixel_q;
        fifo_pop_o    = 1'b0;
        shift_load_o  = 1'b0;
        load_zero_o   = 1'b0;
        shift_next_o  = 1'b0;
        timer_clear_o = 1'b0;
        // Timer runs in every active state
        timer_en_o    = (state_q != IDLE);

        case (state_q)
            IDLE: begin
                if (!fifo_empty_i && (num_neopixel_i != '0)) begin
                    // First pixel of a frame
                    fifo_pop_o    = 1'b1;
                    shift_load_o  = 1'b1;
                    timer_clear_o = 1'b1;
                    pixel_d       = '0;
                    state_d       = BIT_HIGH;
                end
            end
            BIT_HIGH: begin
                if (timer_last_i) begin
                    timer_clear_o = 1'b1;
                    state_d       = BIT_LOW;
                end
            end
            BIT_LOW: begin
                if (timer_last_i) begin
                    timer_clear_o = 1'b1;
                    if (!last_bit_i) begin
                        // Same pixel, next bit
                        shift_next_o = 1'b1;
                        state_d      = BIT_HIGH;
                    end else if ((pixel_q + 1'b1) < num_neopixel_i) begin
                        // Next pixel, zero colour once the FIFO runs dry
                        shift_load_o = 1'b1;
                        fifo_pop_o   = !fifo_empty_i;
                        load_zero_o  = fifo_empty_i;
                        pixel_d      = pixel_q + 1'b1;
                        state_d      = BIT_HIGH;
                    end else begin
                        state_d = LATCH;
                    end
                end
            end
            LATCH: begin
                if (timer_last_i) begin
                    if (!fifo_empty_i) begin
                        // Back-to-back frame
                        fifo_pop_o    = 1'b1;
                        shift_load_o  = 1'b1;
                        timer_clear_o = 1'b1;
                        pixel_d       = '0;
                        state_d       = BIT_HIGH;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            pixel_q <= '0;
        end else begin
            state_q <= state_d;
            pixel_q <= pixel_d;
        end
    end

endmodule

//--- hw/neopixel_pixel_pkg.sv
package neopixel_pixel_pkg;

    //////////////////////////////////////////////////
    // Colour word
    //////////////////////////////////////////////////

    // One pixel in GRB order, green in the top byte
    localparam int ColorWidth    = 24;
    // Counts 0..ColorWidth-1 inside a pixel
    localparam int BitIndexWidth = 5;

    //////////////////////////////////////////////////
    // Strip and FIFO sizing
    //////////////////////////////////////////////////

    // Longest supported strip
    localparam int MaxNumNeoPixel  = 64;
    // Holds 0..MaxNumNeoPixel inclusive
    localparam int PixelCountWidth = 7;

    // Colour words buffered ahead of the serializer
    localparam int FifoDepth     = 16;
    localparam int FifoAddrWidth = 4;

endpackage

//--- hw/neopixel_shifter.sv
`timescale 1ns/1ps

module neopixel_shifter (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Capture a new pixel
    input  logic                                      load_i,
    // Load zero colour instead of data_i
    input  logic                                      load_zero_i,
    // Advance to the next bit
    input  logic                                      next_i,
    input  logic [neopixel_pixel_pkg::ColorWidth-1:0] data_i,
    // Bit on the wire, MSB first
    output logic                                      bit_o,
    // Final bit of the pixel is being sent
    output logic                                      last_bit_o
);

    import neopixel_pixel_pkg::*;

    // Pixel being serialized
    logic [ColorWidth-1:0]    shreg_q;
    // Position inside the pixel
    logic [BitIndexWidth-1:0] index_q;

    assign bit_o      = shreg_q[ColorWidth-1];
    assign last_bit_o = (index_q == BitIndexWidth'(ColorWidth - 1));

    // Payload, no reset needed
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            shreg_q <= load_zero_i ? '0 : data_i;
        end else if (next_i) begin
            shreg_q <= {shreg_q[ColorWidth-2:0], 1'b0};
        end
    end

    // Bit counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            index_q <= '0;
        end else if (load_i) begin
            index_q <= '0;
        end else if (next_i) begin
            index_q <= index_q + 1'b1;
        end
    end

endmodule

//--- hw/neopixel_timer.sv
`timescale 1ns/1ps

module neopixel_timer (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Restart the phase, wins over en_i
    input  logic                                      clear_i,
    input  logic                                      en_i,
    // Phase duration in cycles, at least 1
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0] len_i,
    // High on the final cycle of the phase
    output logic                                      last_o
);

    import neopixel_cfg_pkg::*;

    logic [CounterWidth-1:0] count_q;
    logic [CounterWidth-1:0] len_m1;

    // Last cycle index of the programmed phase
    assign len_m1 = len_i - 1'b1;

    // Zero latency, decoded straight from the count
    assign last_o = (count_q == len_m1);

    //////////////////////////////////////////////////
    // Up-counter, sticks at all ones
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (en_i && (count_q != '1)) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

//--- hw/neopixel_timing_regs.sv
`timescale 1ns/1ps

module neopixel_timing_regs (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Host write port, one-cycle strobe
    input  logic                                      cfg_we_i,
    input  logic [neopixel_cfg_pkg::CfgAddrWidth-1:0] cfg_addr_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0] cfg_wdata_i,
    // Timing values in clock cycles
    output logic [neopixel_cfg_pkg::CounterWidth-1:0] t0h_o,
    output logic [neopixel_cfg_pkg::CounterWidth-1:0] t0l_o,
    output logic [neopixel_cfg_pkg::CounterWidth-1:0] t1h_o,
    output logic [neopixel_cfg_pkg::CounterWidth-1:0] t1l_o,
    output logic [neopixel_cfg_pkg::CounterWidth-1:0] t_latch_o,
    // Strip length in pixels
    output logic [neopixel_pixel_pkg::PixelCountWidth-1:0] num_neopixel_o
);

    import neopixel_cfg_pkg::*;
    import neopixel_pixel_pkg::*;

    // Strip length after clipping to the supported maximum
    logic [PixelCountWidth-1:0] num_clipped;

    always_comb begin
        if (cfg_wdata_i > MaxNumNeoPixel) begin
            num_clipped = PixelCountWidth'(MaxNumNeoPixel);
        end else begin
            num_clipped = cfg_wdata_i[PixelCountWidth-1:0];
        end
    end

    // Address decode, unknown addresses fall through untouched
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            t0h_o          <= DefT0h;
            t0l_o          <= DefT0l;
            t1h_o          <= DefT1h;
            t1l_o          <= DefT1l;
            t_latch_o      <= DefTLatch;
            // Empty strip keeps the FSM parked after reset
            num_neopixel_o <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                AddrT0h:      t0h_o          <= cfg_wdata_i;
                AddrT0l:      t0l_o          <= cfg_wdata_i;
                AddrT1h:      t1h_o          <= cfg_wdata_i;
                AddrT1l:      t1l_o          <= cfg_wdata_i;
                AddrTLatch:   t_latch_o      <= cfg_wdata_i;
                AddrNumPixel: num_neopixel_o <= num_clipped;
                default: ;
            endcase
        end
    end

endmodule

//--- hw/neopixel_top.sv
`timescale 1ns/1ps

module neopixel_top (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Register write port
    input  logic                                      cfg_we_i,
    input  logic [neopixel_cfg_pkg::CfgAddrWidth-1:0] cfg_addr_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0] cfg_wdata_i,
    // Colour push port
    input  logic                                      pix_push_i,
    input  logic [neopixel_pixel_pkg::ColorWidth-1:0] pix_data_i,
    // Serial line and status
    output logic                                      data_o,
    output logic                                      busy_o,
    output logic                                      fifo_full_o,
    output logic                                      fifo_empty_o
);

    import neopixel_cfg_pkg::*;
    import neopixel_pixel_pkg::*;

    // Configuration
    logic [CounterWidth-1:0]    t0h, t0l, t1h, t1l, t_latch;
    logic [PixelCountWidth-1:0] num_neopixel;

    // FIFO to FSM and shifter
    logic [ColorWidth-1:0] fifo_head;
    logic                  fifo_empty;
    logic                  fifo_pop;

    // FSM to datapath
    logic                    timer_clear, timer_en, timer_last;
    logic [CounterWidth-1:0] timer_len;
    logic                    shift_load, load_zero, shift_next;
    logic                    cur_bit, last_bit;

    assign fifo_empty_o = fifo_empty;

    neopixel_timing_regs u_regs (
        .clk_i, .rst_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .t0h_o(t0h), .t0l_o(t0l), .t1h_o(t1h), .t1l_o(t1l),
        .t_latch_o(t_latch), .num_neopixel_o(num_neopixel)
    );

    neopixel_fifo u_fifo (
        .clk_i, .rst_i, .push_i(pix_push_i), .push_data_i(pix_data_i),
        .pop_i(fifo_pop), .head_o(fifo_head), .empty_o(fifo_empty), .full_o(fifo_full_o)
    );

    neopixel_timer u_timer (
        .clk_i, .rst_i, .clear_i(timer_clear), .en_i(timer_en),
        .len_i(timer_len), .last_o(timer_last)
    );

    neopixel_shifter u_shifter (
        .clk_i, .rst_i, .load_i(shift_load), .load_zero_i(load_zero), .next_i(shift_next),
        .data_i(fifo_head), .bit_o(cur_bit), .last_bit_o(last_bit)
    );

    neopixel_fsm u_fsm (
        .clk_i, .rst_i, .fifo_empty_i(fifo_empty), .num_neopixel_i(num_neopixel),
        .t0h_i(t0h), .t0l_i(t0l), .t1h_i(t1h), .t1l_i(t1l), .t_latch_i(t_latch),
        .cur_bit_i(cur_bit), .last_bit_i(last_bit), .timer_last_i(timer_last),
        .fifo_pop_o(fifo_pop), .shift_load_o(shift_load), .load_zero_o(load_zero),
        .shift_next_o(shift_next), .timer_clear_o(timer_clear), .timer_en_o(timer_en),
        .timer_len_o(timer_len), .data_o, .busy_o
    );

endmodule

//--- neopixel_strip.f
hw/neopixel_cfg_pkg.sv
hw/neopixel_pixel_pkg.sv
hw/neopixel_timing_regs.sv
hw/neopixel_fifo.sv
hw/neopixel_timer.sv
hw/neopixel_shifter.sv
hw/neopixel_fsm.sv
hw/neopixel_top.sv
testbench/neopixel_sva.sv
testbench/tb_neopixel_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the LED strip testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_neopixel_top \
    -f neopixel_strip.f \
    -o tb_neopixel_top_sim

./obj_dir/tb_neopixel_top_sim 2>&1 | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"

//--- testbench/neopixel_sva.sv
`timescale 1ns/1ps

module neopixel_sva (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    // Serial line and FSM status
    input  logic                                      data_i,
    input  logic                                      busy_i,
    // Programmed high phase lengths
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0] t0h_i,
    input  logic [neopixel_cfg_pkg::CounterWidth-1:0] t1h_i
);

    import neopixel_cfg_pkg::*;

    // Cycles the line has been high so far
    logic [CounterWidth-1:0] high_len_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            high_len_q <= '0;
        end else if (data_i) begin
            high_len_q <= high_len_q + 1'b1;
        end else begin
            high_len_q <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Line protocol
    //////////////////////////////////////////////////

    // Quiet line and idle FSM right out of reset
    a_reset_quiet: assert property (@(posedge clk_i) rst_i |=> (!data_i && !busy_i))
        else $error("data_o or busy_o high after reset");

    // A high pulse ends after exactly t0h or t1h cycles
    a_high_len: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(data_i) |-> ((high_len_q == t0h_i) || (high_len_q == t1h_i)))
        else $error("high pulse of %0d cycles fits neither t0h nor t1h", high_len_q);

    // A frame opens with the line high in its first busy cycle
    a_rise_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(busy_i) |-> data_i)
        else $error("busy_o rose without data_o going high");

endmodule

// Attach the checks to the strip driver
bind neopixel_top neopixel_sva u_sva (
    .clk_i(clk_i), .rst_i(rst_i), .data_i(data_o), .busy_i(busy_o),
    .t0h_i(t0h), .t1h_i(t1h)
);

//--- testbench/tb_neopixel_top.sv
`timescale 1ns/1ps

module tb_neopixel_top;

    import neopixel_cfg_pkg::*;
    import neopixel_pixel_pkg::*;

    //////////////////////////////////////////////////
    // Run length
    //////////////////////////////////////////////////

    // Worst bit with default timing, and with the short values 2, 4, 4, 2
    localparam int DefBitCycles   = int'(DefT0h) + int'(DefT0l);
    localparam int ShortBitCycles = 6;
    localparam int ShortLatch     = 20;
    // Pixels sent with short timing, tests 2 to 5
    localparam int ShortPixels    = 3 + 4 + 2 + 2 + 16;
    localparam int TimeoutCycles  = ColorWidth * DefBitCycles + int'(DefTLatch)
                                  + ColorWidth * ShortBitCycles * ShortPixels
                                  + 5 * ShortLatch + 1000;

    logic                    clk_i;
    logic                    rst_i;
    logic                    cfg_we_i;
    logic [CfgAddrWidth-1:0] cfg_addr_i;
    logic [CounterWidth-1:0] cfg_wdata_i;
    logic                    pix_push_i;
    logic [ColorWidth-1:0]   pix_data_i;
    logic                    data_o;
    logic                    busy_o;
    logic                    fifo_full_o;
    logic                    fifo_empty_o;

    // Timing as last written, in cycles
    int t0h_v, t0l_v, t1h_v, t1l_v, tlatch_v;
    // Bits per frame for the current strip length
    int frame_bits = 0;
    // Bits still to appear on the line, MSB first
    bit exp_bits[$];

    // Decoder state
    logic prev_line;
    logic seen_bit;
    int   high_cnt, low_cnt, exact_low, gap_min, frame_pos;
    int   bits_seen = 0;

    int          error_count   = 0;
    int          errors_before = 0;
    int          test_count    = 0;
    int          pass_count    = 0;
    int          cycle_count   = 0;
    int          target;

    neopixel_top u_dut (
        .clk_i, .rst_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
        .pix_push_i, .pix_data_i, .data_o, .busy_o, .fifo_full_o, .fifo_empty_o
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Hard stop for a stuck FSM
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TimeoutCycles) begin
            $display("Timeout: no end of run after %0d cycles", TimeoutCycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_that(input logic cond, input string msg);
        assert (cond) else begin
            $display("FAILED t=%0t: %s", $time, msg);
            error_count++;
        end
    endtask

    task automatic write_reg(input logic [CfgAddrWidth-1:0] addr,
                             input logic [CounterWidth-1:0] value);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= value;
        @(posedge clk_i);
        cfg_we_i    <= 1'b0;
        // Register map model, strip length clips at the supported maximum
        case (addr)
            AddrT0h:      t0h_v    = int'(value);
            AddrT0l:      t0l_v    = int'(value);
            AddrT1h:      t1h_v    = int'(value);
            AddrT1l:      t1l_v    = int'(value);
            AddrTLatch:   tlatch_v = int'(value);
            AddrNumPixel: begin
                frame_bits = ColorWidth
                           * ((value > MaxNumNeoPixel) ? MaxNumNeoPixel : int'(value));
            end
            default: ;
        endcase
    endtask

    // Back-to-back pushes, only the first kept words are expected on the line
    task automatic push_random(input int count, input int kept);
        logic [ColorWidth-1:0] word;
        for (int n = 0; n < count; n++) begin
            word = ColorWidth'($urandom);
            @(posedge clk_i);
            pix_push_i <= 1'b1;
            pix_data_i <= word;
            if (n < kept) begin
                for (int b = ColorWidth - 1; b >= 0; b--) begin
                    exp_bits.push_back(word[b]);
                end
            end
        end
        @(posedge clk_i);
        pix_push_i <= 1'b0;
    endtask

    // One busy period, every queued bit sent and a full latch at the end
    task automatic run_frame();
        while (!busy_o) @(negedge clk_i);
        while (busy_o) @(negedge clk_i);
        // Decoder has counted the first idle cycle by the next rising edge
        @(posedge clk_i);
        check_that(exp_bits.size() == 0,
                   $sformatf("%0d expected bits never appeared", exp_bits.size()));
        check_that(low_cnt == gap_min + 1,
                   $sformatf("%0d low cycles after the last pulse, expected %0d",
                             low_cnt - 1, gap_min));
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    //////////////////////////////////////////////////
    // Waveform decoder
    //////////////////////////////////////////////////

    // Called on a falling edge of the line
    task automatic decode_bit();
        logic got;
        logic want;
        got = 1'b0;
        if (high_cnt == t1h_v) begin
            got = 1'b1;
        end else begin
            check_that(high_cnt == t0h_v,
                       $sformatf("high of %0d cycles is neither t0h nor t1h", high_cnt));
        end
        if (exp_bits.size() == 0) begin
            check_that(1'b0, "pulse on data_o with no bit expected");
        end else begin
            want = exp_bits.pop_front();
            check_that(got == want,
                       $sformatf("frame bit %0d is %0b, expected %0b", frame_pos, got, want));
        end
        // Low phase of this bit, plus the latch when the frame ends here
        exact_low = got ? t1l_v : t0l_v;
        gap_min   = exact_low + tlatch_v;
        bits_seen++;
        frame_pos++;
        if (frame_pos >= frame_bits) begin
            frame_pos = 0;
        end
        seen_bit = 1'b1;
    endtask

    // Sampled mid-cycle, away from the DUT edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            high_cnt  = 0;
            low_cnt   = 0;
            frame_pos = 0;
            seen_bit  = 1'b0;
            prev_line = 1'b0;
        end else if (data_o) begin
            if (!prev_line) begin
                check_that(busy_o, "rise of data_o while busy_o is low");
                // No gap allowed inside a frame, latch between frames
                if (seen_bit && (frame_pos != 0)) begin
                    check_that(low_cnt == exact_low,
                               $sformatf("low of %0d cycles, expected %0d", low_cnt, exact_low));
                end else if (seen_bit) begin
                    check_that(low_cnt >= gap_min,
                               $sformatf("frame gap %0d, wanted %0d", low_cnt, gap_min));
                end
                high_cnt = 0;
            end
            high_cnt++;
            prev_line = 1'b1;
        end else begin
            if (prev_line) begin
                decode_bit();
                low_cnt = 0;
            end
            low_cnt++;
            prev_line = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc5c1));
        rst_i       = 1'b1;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = '0;
        cfg_wdata_i = '0;
        pix_push_i  = 1'b0;
        pix_data_i  = '0;
        t0h_v       = int'(DefT0h);
        t0l_v       = int'(DefT0l);
        t1h_v       = int'(DefT1h);
        t1l_v       = int'(DefT1l);
        tlatch_v    = int'(DefTLatch);
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        // 1: quiet after reset, then one pixel at default timing
        @(negedge clk_i);
        check_that(!data_o && !busy_o && fifo_empty_o, "outputs wrong after reset");
        repeat (8) begin
            @(negedge clk_i);
            check_that(!data_o && !busy_o, "activity with an empty FIFO");
        end
        write_reg(AddrNumPixel, 16'd1);
        push_random(1, 1);
        run_frame();
        close_test("reset_default_timing");

        // 2: short timing, three pixels queued before the strip length is set
        write_reg(AddrT0h, 16'd2);
        write_reg(AddrT0l, 16'd4);
        write_reg(AddrT1h, 16'd4);
        write_reg(AddrT1l, 16'd2);
        write_reg(AddrTLatch, 16'(ShortLatch));
        write_reg(AddrNumPixel, 16'd0);
        push_random(3, 3);
        write_reg(AddrNumPixel, 16'd3);
        run_frame();
        close_test("three_random_pixels");

        // 3: two words on a strip of four, the rest is zero colour
        write_reg(AddrNumPixel, 16'd4);
        push_random(2, 2);
        for (int b = 0; b < 2 * ColorWidth; b++) begin
            exp_bits.push_back(1'b0);
        end
        run_frame();
        close_test("zero_fill");

        // 4: words pushed in the latch start the next frame at once
        write_reg(AddrNumPixel, 16'd2);
        target = bits_seen + 2 * ColorWidth;
        push_random(2, 2);
        while (bits_seen < target) @(negedge clk_i);
        // Past the last low phase, inside the latch
        repeat (ShortBitCycles) @(negedge clk_i);
        push_random(2, 2);
        while (exp_bits.size() != 0) begin
            @(negedge clk_i);
            check_that(busy_o, "busy_o dropped between back-to-back frames");
        end
        run_frame();
        close_test("back_to_back");

        // 5: overfill the FIFO with the strip disabled
        write_reg(AddrNumPixel, 16'd0);
        push_random(FifoDepth + 4, FifoDepth);
        @(negedge clk_i);
        check_that(fifo_full_o, "fifo_full_o low after overfilling");
        repeat (ShortLatch) begin
            @(negedge clk_i);
            check_that(!data_o && !busy_o, "frame sent with a strip length of zero");
        end
        write_reg(AddrNumPixel, 16'(FifoDepth));
        run_frame();
        close_test("fifo_full_drop");

        // 6: drained FIFO leaves the FSM idle
        repeat (ShortLatch) begin
            @(negedge clk_i);
            check_that(!data_o && !busy_o && fifo_empty_o,
                       "line active or FIFO not empty after the drain");
        end
        close_test("drain_to_idle");

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
